/* verilog/dc_bridge_consts.svh */
// DC_SLOTS has to stay twice DC_TOKEN_WIDTH and DC_SYNC_STAGES must be at least 1
`ifndef DC_BRIDGE_CONSTS_SVH
`define DC_BRIDGE_CONSTS_SVH

// AXI4 field widths
`define DC_ADDR_WIDTH 32
`define DC_DATA_WIDTH 64
`define DC_ID_WIDTH 6
`define DC_USER_WIDTH 6

// Johnson pointer width and the ring depth it implies
`define DC_TOKEN_WIDTH 4
`define DC_SLOTS (2 * `DC_TOKEN_WIDTH)

// Flops per token bit on each crossing
`define DC_SYNC_STAGES 2

`endif

/* verilog/dc_bridge_pkg.sv */
// AXI4 write-path beats with a one-bit lock and Johnson pointer helpers for DC_TOKEN_WIDTH >= 2
`default_nettype none
`include "dc_bridge_consts.svh"

package dc_bridge_pkg;

    typedef logic [`DC_TOKEN_WIDTH-1:0] dc_token_t;

    typedef struct packed {
        logic [`DC_ADDR_WIDTH-1:0] addr;
        logic [2:0]                prot;
        logic [3:0]                region;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
        logic                      lock;
        logic [3:0]                cache;
        logic [3:0]                qos;
        logic [`DC_ID_WIDTH-1:0]   id;
        logic [`DC_USER_WIDTH-1:0] user;
    } aw_beat_t;

    typedef struct packed {
        logic [`DC_DATA_WIDTH-1:0]   data;
        logic [`DC_DATA_WIDTH/8-1:0] strb;
        logic [`DC_USER_WIDTH-1:0]   user;
        logic                        last;
    } w_beat_t;

    typedef struct packed {
        logic [1:0]                resp;
        logic [`DC_ID_WIDTH-1:0]   id;
        logic [`DC_USER_WIDTH-1:0] user;
    } b_beat_t;

    // One Johnson step, inverted MSB shifts in at the bottom
    function automatic dc_token_t johnson_next(dc_token_t t);
        return {t[`DC_TOKEN_WIDTH-2:0], ~t[`DC_TOKEN_WIDTH-1]};
    endfunction

    // Code held after k steps from all zeros
    function automatic dc_token_t johnson_code(int unsigned k);
        dc_token_t ones;
        ones = '1;
        if (k < `DC_TOKEN_WIDTH) begin
            return ~(ones << k);
        end
        return ones << (k - `DC_TOKEN_WIDTH);
    endfunction

    // Slot decode, all zeros for an illegal code
    function automatic logic [`DC_SLOTS-1:0] johnson_onehot(dc_token_t t);
        logic [`DC_SLOTS-1:0] sel;
        sel = '0;
        for (int k = 0; k < `DC_SLOTS; k++) begin
            sel[k] = (t == johnson_code(k));
        end
        return sel;
    endfunction

endpackage

`default_nettype wire

/* verilog/dc_token_counter.sv */
// Resets to the all-zero Johnson code and steps once per clk_i edge with advance high
`default_nettype none
`include "dc_bridge_consts.svh"

module dc_token_counter (
    input  logic                     clk_i,
    input  logic                     arst_n,
    input  logic                     advance,
    output dc_bridge_pkg::dc_token_t token,
    output logic [`DC_SLOTS-1:0]     slot_sel
);

    import dc_bridge_pkg::*;

    dc_token_t token_q;

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            token_q <= '0;
        end else if (advance) begin
            token_q <= johnson_next(token_q);
        end
    end

    assign token = token_q;

    // Slot the pointer currently names
    assign slot_sel = johnson_onehot(token_q);

endmodule

`default_nettype wire

/* verilog/dc_fifo_dout.sv */
// Receiving ring end, data_async must come from a sender that writes a slot before announcing it
`default_nettype none
`include "dc_bridge_consts.svh"

module dc_fifo_dout #(
    parameter type beat_t = logic
) (
    input  logic                     clk_i,
    input  logic                     arst_n,

    // Peer side
    input  dc_bridge_pkg::dc_token_t write_token,
    input  beat_t                    data_async,
    output dc_bridge_pkg::dc_token_t read_pointer,

    // Local valid/ready side
    output logic                     valid,
    input  logic                     ready,
    output beat_t                    data
);

    import dc_bridge_pkg::*;

    dc_token_t wt_sync_q [`DC_SYNC_STAGES];
    dc_token_t wt_seen;
    logic      pop;

    // Token synchronizer, one Johnson bit changes per step
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DC_SYNC_STAGES; i++) begin
                wt_sync_q[i] <= '0;
            end
        end else begin
            wt_sync_q[0] <= write_token;
            for (int i = 1; i < `DC_SYNC_STAGES; i++) begin
                wt_sync_q[i] <= wt_sync_q[i-1];
            end
        end
    end

    assign wt_seen = wt_sync_q[`DC_SYNC_STAGES-1];

    // Ring holds something while the pointers differ
    assign valid = (wt_seen != read_pointer);
    assign pop   = valid && ready;

    // Peer muxes its own slot array by our pointer
    assign data = data_async;

    dc_token_counter u_read_pointer (
        .clk_i    ( clk_i        ),
        .arst_n   ( arst_n       ),
        .advance  ( pop          ),
        .token    ( read_pointer ),
        .slot_sel (              )
    );

    // The peer must not touch a slot that is still announced and unread
    a_hold_until_ready: assert property (
        @(posedge clk_i) disable iff (!arst_n)
        (valid && !ready) |=> (valid && $stable(data))
    ) else $error("beat changed or dropped before ready");

endmodule

`default_nettype wire

/* verilog/dc_fifo_din.sv */
// Sending ring end, carries at most DC_SLOTS-1 beats and read_pointer drives the output mux directly
`default_nettype none
`include "dc_bridge_consts.svh"

module dc_fifo_din #(
    parameter type beat_t = logic
) (
    input  logic                     clk_i,
    input  logic                     arst_n,

    // Local valid/ready side
    input  logic                     valid,
    output logic                     ready,
    input  beat_t                    data,

    // Peer side
    output dc_bridge_pkg::dc_token_t write_token,
    input  dc_bridge_pkg::dc_token_t read_pointer,
    output beat_t                    data_async
);

    import dc_bridge_pkg::*;

    beat_t                slots_q [`DC_SLOTS];
    dc_token_t            rp_sync_q [`DC_SYNC_STAGES];
    logic [`DC_SLOTS-1:0] wr_sel;
    logic [`DC_SLOTS-1:0] rd_sel;
    logic                 full;
    logic                 push;

    // Peer pointer synchronizer for the full check
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DC_SYNC_STAGES; i++) begin
                rp_sync_q[i] <= '0;
            end
        end else begin
            rp_sync_q[0] <= read_pointer;
            for (int i = 1; i < `DC_SYNC_STAGES; i++) begin
                rp_sync_q[i] <= rp_sync_q[i-1];
            end
        end
    end

    // One slot always stays free
    assign full  = (johnson_next(write_token) == rp_sync_q[`DC_SYNC_STAGES-1]);
    assign ready = !full;
    assign push  = valid && ready;

    dc_token_counter u_write_token (
        .clk_i    ( clk_i       ),
        .arst_n   ( arst_n      ),
        .advance  ( push        ),
        .token    ( write_token ),
        .slot_sel ( wr_sel      )
    );

    // Slot written on the same edge the token moves past it
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < `DC_SLOTS; k++) begin
            if (push && wr_sel[k]) begin
                slots_q[k] <= data;
            end
        end
    end

    // Slot under the peer's read pointer
    assign rd_sel = johnson_onehot(read_pointer);

    always_comb begin
        data_async = slots_q[0];
        for (int k = 1; k < `DC_SLOTS; k++) begin
            if (rd_sel[k]) begin
                data_async = slots_q[k];
            end
        end
    end

    // Synchronized pointer lags the real one, so a write must never land on the
    // slot the peer is still reading
    a_no_overrun: assert property (
        @(posedge clk_i) disable iff (!arst_n)
        push |-> (johnson_next(write_token) != read_pointer)
    ) else $error("ring overrun, write token caught the peer read pointer");

endmodule

`default_nettype wire

/* verilog/axi_slice_dc_master.sv */
// Master side of the write path only, AR and R are not bridged and local ports run on clk_i
`default_nettype none
`include "dc_bridge_consts.svh"

module axi_slice_dc_master (
    input  logic                        clk_i,
    input  logic                        arst_n,

    // Peer AW
    input  dc_bridge_pkg::dc_token_t    aw_writetoken,
    input  dc_bridge_pkg::aw_beat_t     aw_data_async,
    output dc_bridge_pkg::dc_token_t    aw_readpointer,

    // Peer W
    input  dc_bridge_pkg::dc_token_t    w_writetoken,
    input  dc_bridge_pkg::w_beat_t      w_data_async,
    output dc_bridge_pkg::dc_token_t    w_readpointer,

    // Peer B
    output dc_bridge_pkg::dc_token_t    b_writetoken,
    output dc_bridge_pkg::b_beat_t      b_data_async,
    input  dc_bridge_pkg::dc_token_t    b_readpointer,

    // Local AW
    output logic                        aw_valid,
    input  logic                        aw_ready,
    output logic [`DC_ADDR_WIDTH-1:0]   aw_addr,
    output logic [2:0]                  aw_prot,
    output logic [3:0]                  aw_region,
    output logic [7:0]                  aw_len,
    output logic [2:0]                  aw_size,
    output logic [1:0]                  aw_burst,
    output logic                        aw_lock,
    output logic [3:0]                  aw_cache,
    output logic [3:0]                  aw_qos,
    output logic [`DC_ID_WIDTH-1:0]     aw_id,
    output logic [`DC_USER_WIDTH-1:0]   aw_user,

    // Local W
    output logic                        w_valid,
    input  logic                        w_ready,
    output logic [`DC_DATA_WIDTH-1:0]   w_data,
    output logic [`DC_DATA_WIDTH/8-1:0] w_strb,
    output logic [`DC_USER_WIDTH-1:0]   w_user,
    output logic                        w_last,

    // Local B
    input  logic                        b_valid,
    output logic                        b_ready,
    input  logic [1:0]                  b_resp,
    input  logic [`DC_ID_WIDTH-1:0]     b_id,
    input  logic [`DC_USER_WIDTH-1:0]   b_user
);

    import dc_bridge_pkg::*;

    aw_beat_t aw_beat;
    w_beat_t  w_beat;
    b_beat_t  b_beat;

    dc_fifo_dout #(.beat_t(aw_beat_t)) u_aw_fifo (
        .clk_i        ( clk_i          ),
        .arst_n       ( arst_n         ),
        .write_token  ( aw_writetoken  ),
        .data_async   ( aw_data_async  ),
        .read_pointer ( aw_readpointer ),
        .valid        ( aw_valid       ),
        .ready        ( aw_ready       ),
        .data         ( aw_beat        )
    );

    assign aw_addr   = aw_beat.addr;
    assign aw_prot   = aw_beat.prot;
    assign aw_region = aw_beat.region;
    assign aw_len    = aw_beat.len;
    assign aw_size   = aw_beat.size;
    assign aw_burst  = aw_beat.burst;
    assign aw_lock   = aw_beat.lock;
    assign aw_cache  = aw_beat.cache;
    assign aw_qos    = aw_beat.qos;
    assign aw_id     = aw_beat.id;
    assign aw_user   = aw_beat.user;

    dc_fifo_dout #(.beat_t(w_beat_t)) u_w_fifo (
        .clk_i        ( clk_i         ),
        .arst_n       ( arst_n        ),
        .write_token  ( w_writetoken  ),
        .data_async   ( w_data_async  ),
        .read_pointer ( w_readpointer ),
        .valid        ( w_valid       ),
        .ready        ( w_ready       ),
        .data         ( w_beat        )
    );

    assign w_data = w_beat.data;
    assign w_strb = w_beat.strb;
    assign w_user = w_beat.user;
    assign w_last = w_beat.last;

    // Response goes back to the peer
    assign b_beat = '{resp: b_resp, id: b_id, user: b_user};

    dc_fifo_din #(.beat_t(b_beat_t)) u_b_fifo (
        .clk_i        ( clk_i         ),
        .arst_n       ( arst_n        ),
        .valid        ( b_valid       ),
        .ready        ( b_ready       ),
        .data         ( b_beat        ),
        .write_token  ( b_writetoken  ),
        .read_pointer ( b_readpointer ),
        .data_async   ( b_data_async  )
    );

endmodule

`default_nettype wire

/* sim/dc_peer_model.sv */
// Remote half on the local clk_i, its own tokens start at the all-zero code and ignore arst_n
`default_nettype none
`include "dc_bridge_consts.svh"

module dc_peer_model (
    input  logic                     clk_i,
    input  logic                     arst_n,
    output dc_bridge_pkg::dc_token_t aw_writetoken,
    output dc_bridge_pkg::aw_beat_t  aw_data_async,
    input  dc_bridge_pkg::dc_token_t aw_readpointer,
    output dc_bridge_pkg::dc_token_t w_writetoken,
    output dc_bridge_pkg::w_beat_t   w_data_async,
    input  dc_bridge_pkg::dc_token_t w_readpointer,
    input  dc_bridge_pkg::dc_token_t b_writetoken,
    input  dc_bridge_pkg::b_beat_t   b_data_async,
    output dc_bridge_pkg::dc_token_t b_readpointer,
    output logic                     aw_full,
    output logic                     w_full
);

    import dc_bridge_pkg::*;

    dc_token_t aw_tok = '0;
    dc_token_t w_tok = '0;
    dc_token_t b_rp = '0;
    aw_beat_t  aw_slots [`DC_SLOTS];
    w_beat_t   w_slots [`DC_SLOTS];
    dc_token_t aw_rp_sync [`DC_SYNC_STAGES];
    dc_token_t w_rp_sync [`DC_SYNC_STAGES];
    dc_token_t b_wt_sync [`DC_SYNC_STAGES];

    // Shift the inverted top bit in at the bottom
    function automatic dc_token_t step(dc_token_t t);
        return {t[`DC_TOKEN_WIDTH-2:0], ~t[`DC_TOKEN_WIDTH-1]};
    endfunction

    // Ring position of a code, counted in steps from all zeros
    function automatic int slot_of(dc_token_t t);
        if (t[`DC_TOKEN_WIDTH-1]) begin
            return `DC_SLOTS - $countones(t);
        end
        return $countones(t);
    endfunction

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DC_SYNC_STAGES; i++) begin
                aw_rp_sync[i] <= '0;
                w_rp_sync[i]  <= '0;
                b_wt_sync[i]  <= '0;
            end
        end else begin
            aw_rp_sync[0] <= aw_readpointer;
            w_rp_sync[0]  <= w_readpointer;
            b_wt_sync[0]  <= b_writetoken;
            for (int i = 1; i < `DC_SYNC_STAGES; i++) begin
                aw_rp_sync[i] <= aw_rp_sync[i-1];
                w_rp_sync[i]  <= w_rp_sync[i-1];
                b_wt_sync[i]  <= b_wt_sync[i-1];
            end
        end
    end

    assign aw_writetoken = aw_tok;
    assign w_writetoken  = w_tok;
    assign b_readpointer = b_rp;
    assign aw_full = (step(aw_tok) == aw_rp_sync[`DC_SYNC_STAGES-1]);
    assign w_full  = (step(w_tok) == w_rp_sync[`DC_SYNC_STAGES-1]);

    // DUT picks the slot with its own read pointer
    assign aw_data_async = aw_slots[slot_of(aw_readpointer)];
    assign w_data_async  = w_slots[slot_of(w_readpointer)];

    task automatic push_aw(input aw_beat_t beat, input int limit, output bit ok);
        ok = 1'b0;
        for (int c = 0; c < limit && !ok; c++) begin
            @(posedge clk_i);
            if (!aw_full) begin
                aw_slots[slot_of(aw_tok)] <= beat;
                aw_tok <= step(aw_tok);
                ok = 1'b1;
            end
        end
    endtask

    task automatic push_w(input w_beat_t beat, input int limit, output bit ok);
        ok = 1'b0;
        for (int c = 0; c < limit && !ok; c++) begin
            @(posedge clk_i);
            if (!w_full) begin
                w_slots[slot_of(w_tok)] <= beat;
                w_tok <= step(w_tok);
                ok = 1'b1;
            end
        end
    endtask

    task automatic pop_b(input int limit, output b_beat_t beat, output bit ok);
        ok = 1'b0;
        beat = '0;
        for (int c = 0; c < limit && !ok; c++) begin
            @(posedge clk_i);
            if (b_wt_sync[`DC_SYNC_STAGES-1] != b_rp) begin
                beat = b_data_async;
                b_rp <= step(b_rp);
                ok = 1'b1;
            end
        end
    endtask

endmodule

`default_nettype wire

/* sim/tb_axi_slice_dc_master.sv */
// Peer shares clk_i with the DUT, so crossings see synchronizer latency but never real clock skew
`default_nettype none
`include "dc_bridge_consts.svh"

module tb_axi_slice_dc_master;

    import dc_bridge_pkg::*;

    localparam int unsigned SEED = 32'h72b9_fca4;
    localparam int STREAM_BEATS = 20;
    localparam int PUSH_LIMIT = 100;
    localparam int DRAIN_LIMIT = 2000;
    localparam int B_OFFER_CYCLES = 24;
    localparam int READY_LOW = 0;
    localparam int READY_HIGH = 1;
    localparam int READY_RANDOM = 2;

    logic clk_i = 1'b0;
    logic arst_n = 1'b0;
    dc_token_t aw_writetoken, aw_readpointer;
    dc_token_t w_writetoken, w_readpointer;
    dc_token_t b_writetoken, b_readpointer;
    aw_beat_t aw_data_async;
    w_beat_t w_data_async;
    b_beat_t b_data_async;
    logic aw_valid, aw_lock, w_valid, w_last;
    logic aw_full, w_full, b_ready;
    logic aw_ready = 1'b0;
    logic w_ready = 1'b0;
    logic b_valid = 1'b0;
    logic [`DC_ADDR_WIDTH-1:0] aw_addr;
    logic [2:0] aw_prot, aw_size;
    logic [3:0] aw_region, aw_cache, aw_qos;
    logic [7:0] aw_len;
    logic [1:0] aw_burst;
    logic [`DC_ID_WIDTH-1:0] aw_id;
    logic [`DC_USER_WIDTH-1:0] aw_user, w_user;
    logic [`DC_DATA_WIDTH-1:0] w_data;
    logic [`DC_DATA_WIDTH/8-1:0] w_strb;
    logic [1:0] b_resp = '0;
    logic [`DC_ID_WIDTH-1:0] b_id = '0;
    logic [`DC_USER_WIDTH-1:0] b_user = '0;
    aw_beat_t aw_exp [$];
    w_beat_t w_exp [$];
    b_beat_t b_exp [$];
    int ready_mode = READY_LOW;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int errors_at_start = 0;
    string cur_test = "none";

    always #20 clk_i = ~clk_i;

    axi_slice_dc_master u_axi_slice_dc_master (.*);
    dc_peer_model u_peer (.*);

    always @(posedge clk_i) begin
        aw_ready <= (ready_mode == READY_RANDOM) ? ($urandom_range(0, 1) == 1)
                                                 : (ready_mode == READY_HIGH);
        w_ready  <= (ready_mode == READY_RANDOM) ? ($urandom_range(0, 1) == 1)
                                                 : (ready_mode == READY_HIGH);
    end

    task automatic note_error(string msg);
        errors++;
        $display("%s: %s", cur_test, msg);
    endtask

    task automatic compare(string what, logic [127:0] expected, logic [127:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
        end
    endtask

    task automatic stall(string what);
        $display("%s: timeout waiting for %s", cur_test, what);
        $display("Test FAILED");
        $finish;
    endtask

    // A stalled beat must stay put until the slave takes it
    a_aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n)
        (aw_valid && !aw_ready) |=> (aw_valid && $stable({aw_addr, aw_prot, aw_region,
            aw_len, aw_size, aw_burst, aw_lock, aw_cache, aw_qos, aw_id, aw_user})))
        else note_error("AW beat dropped or changed while stalled");

    a_w_hold: assert property (@(posedge clk_i) disable iff (!arst_n)
        (w_valid && !w_ready) |=> (w_valid && $stable({w_data, w_strb, w_user, w_last})))
        else note_error("W beat dropped or changed while stalled");

    // Scoreboards for the beats leaving on the local ports
    always @(posedge clk_i) begin
        if (arst_n && aw_valid && aw_ready) begin
            if (aw_exp.size() == 0) begin
                note_error("AW beat arrived with none outstanding");
            end else begin
                compare("aw beat", aw_exp.pop_front(), {aw_addr, aw_prot, aw_region, aw_len,
                    aw_size, aw_burst, aw_lock, aw_cache, aw_qos, aw_id, aw_user});
            end
        end
        if (arst_n && w_valid && w_ready) begin
            if (w_exp.size() == 0) begin
                note_error("W beat arrived with none outstanding");
            end else begin
                compare("w beat", w_exp.pop_front(), {w_data, w_strb, w_user, w_last});
            end
        end
    end

    task automatic start_test(string name);
        cur_test = name;
        errors_at_start = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("%-10s done, %0d errors", cur_test, errors - errors_at_start);
    endtask

    function automatic logic [127:0] random_bits();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic check_idle();
        compare("aw_valid", 0, aw_valid);
        compare("w_valid", 0, w_valid);
        compare("b_ready", 1, b_ready);
        compare("aw_readpointer", 0, aw_readpointer);
        compare("w_readpointer", 0, w_readpointer);
        compare("b_writetoken", 0, b_writetoken);
    endtask

    task automatic send_aw(int n);
        bit ok;
        aw_beat_t beat;
        for (int i = 0; i < n; i++) begin
            beat = aw_beat_t'(random_bits());
            aw_exp.push_back(beat);
            u_peer.push_aw(beat, PUSH_LIMIT, ok);
            if (!ok) begin
                stall("a free AW slot in the peer");
            end
        end
    endtask

    task automatic send_w(int n);
        bit ok;
        w_beat_t beat;
        for (int i = 0; i < n; i++) begin
            beat = w_beat_t'(random_bits());
            w_exp.push_back(beat);
            u_peer.push_w(beat, PUSH_LIMIT, ok);
            if (!ok) begin
                stall("a free W slot in the peer");
            end
        end
    endtask

    task automatic drain(string what);
        for (int c = 0; aw_exp.size() + w_exp.size() != 0; c++) begin
            if (c == DRAIN_LIMIT) begin
                stall(what);
            end
            @(posedge clk_i);
        end
    endtask

    task automatic fill_and_drain_b();
        b_beat_t beat;
        b_beat_t got;
        bit ok;
        int accepted;
        accepted = 0;
        beat = b_beat_t'(random_bits());
        {b_resp, b_id, b_user} <= beat;
        b_valid <= 1'b1;
        // Peer is not reading, so the ring fills and stays full
        for (int c = 0; c < B_OFFER_CYCLES; c++) begin
            @(posedge clk_i);
            if (b_valid && b_ready) begin
                b_exp.push_back({b_resp, b_id, b_user});
                accepted++;
                beat = b_beat_t'(random_bits());
                {b_resp, b_id, b_user} <= beat;
            end
        end
        b_valid <= 1'b0;
        compare("b beats accepted", `DC_SLOTS - 1, accepted);
        compare("b_ready while full", 0, b_ready);
        while (b_exp.size() != 0) begin
            u_peer.pop_b(PUSH_LIMIT, got, ok);
            if (!ok) begin
                stall("a B beat at the peer");
            end
            compare("b beat", b_exp.pop_front(), got);
        end
        for (int c = 0; !b_ready; c++) begin
            if (c == DRAIN_LIMIT) begin
                stall("b_ready to rise");
            end
            @(posedge clk_i);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        start_test("reset");
        repeat (4) @(posedge clk_i);
        check_idle();
        repeat (4) @(posedge clk_i);
        arst_n <= 1'b1;
        @(posedge clk_i);
        check_idle();
        end_test();

        start_test("aw_order");
        ready_mode <= READY_HIGH;
        send_aw(STREAM_BEATS);
        drain("AW beats to leave");
        end_test();

        start_test("w_order");
        send_w(STREAM_BEATS);
        drain("W beats to leave");
        end_test();

        start_test("backpress");
        ready_mode <= READY_LOW;
        @(posedge clk_i);
        fork
            send_aw(`DC_SLOTS - 1);
            send_w(`DC_SLOTS - 1);
        join
        @(posedge clk_i);
        compare("peer aw full", 1, aw_full);
        compare("peer w full", 1, w_full);
        compare("aw beats held", `DC_SLOTS - 1, aw_exp.size());
        compare("w beats held", `DC_SLOTS - 1, w_exp.size());
        ready_mode <= READY_RANDOM;
        fork
            send_aw(STREAM_BEATS - `DC_SLOTS + 1);
            send_w(STREAM_BEATS - `DC_SLOTS + 1);
        join
        drain("stalled beats to leave");
        ready_mode <= READY_HIGH;
        end_test();

        start_test("b_full");
        fill_and_drain_b();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/dc_bridge_pkg.sv
verilog/dc_token_counter.sv
verilog/dc_fifo_dout.sv
verilog/dc_fifo_din.sv
verilog/axi_slice_dc_master.sv
sim/dc_peer_model.sv
sim/tb_axi_slice_dc_master.sv
